//--- hw/ts_pkg.sv
package ts_pkg;

	// layers walked per line, in walk order
	localparam int layers = 6;
	localparam int lyr_tm = 0;
	localparam int lyr_s0 = 1;
	localparam int lyr_t0 = 2;
	localparam int lyr_s1 = 3;
	localparam int lyr_t1 = 4;
	localparam int lyr_s2 = 5;

	// DRAM word address and on-chip memory sizes
	localparam int gfx_addr_w = 21;
	localparam int sfile_aw = 8;
	localparam int tmb_aw = 9;

	// descriptor index that closes every sprite layer
	localparam logic [sfile_aw-1:0] sfile_last = 8'd255;

	typedef struct packed {
		logic       yflp;
		logic       leap;
		logic       act;
		logic       spare;
		logic [2:0] ysz;
		logic [8:0] ycrd;
	} sfile_r0_t;

	typedef struct packed {
		logic       xflp;
		logic [2:0] spare;
		logic [2:0] xsz;
		logic [8:0] xcrd;
	} sfile_r1_t;

	typedef struct packed {
		logic [3:0]  pal;
		logic [11:0] tnum;
	} sfile_r2_t;

	// one sprite file word, meaning depends on walker phase
	typedef union packed {
		sfile_r0_t r0;
		sfile_r1_t r1;
		sfile_r2_t r2;
	} sfile_word_u;

	typedef struct packed {
		logic        yflp;
		logic        xflp;
		logic [1:0]  pal;
		logic [11:0] tnum;
	} tile_desc_t;

endpackage

//--- hw/ts_task_if.sv
`timescale 1ns/1ps

interface ts_task_if;
	// one-cycle task strobe, only while rdy is high
	logic       go;
	// renderer idle
	logic       rdy;
	// graphics page, bitmap line and 8-pixel column
	logic [7:0] page;
	logic [8:0] line;
	logic [5:0] addr;
	// line buffer start position, size in 8-pixel steps
	logic [8:0] x;
	logic [2:0] xs;
	logic       xf;
	logic [3:0] pal;

	modport seq (output go, page, line, addr, x, xs, xf, pal, input rdy);

	modport rend (input go, page, line, addr, x, xs, xf, pal, output rdy);

endinterface

//--- hw/video_sfile.sv
`timescale 1ns/1ps

module video_sfile (
	input  logic                        clk,
	input  logic [ts_pkg::sfile_aw-1:0] waddr,
	input  logic [15:0]                 wdata,
	input  logic                        we,
	input  logic [ts_pkg::sfile_aw-1:0] raddr,
	output logic [15:0]                 rdata
);
	import ts_pkg::*;

	// three words per sprite, r0 r1 r2
	logic [15:0] mem [0:(1 << sfile_aw)-1];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

//--- hw/video_tmbuf.sv
`timescale 1ns/1ps

module video_tmbuf (
	input  logic                      clk,
	input  logic [ts_pkg::tmb_aw-1:0] waddr,
	input  logic [15:0]               wdata,
	input  logic                      we,
	input  logic [ts_pkg::tmb_aw-1:0] raddr,
	output logic [15:0]               rdata
);
	import ts_pkg::*;

	// 4 row slots x 64 columns x 2 planes
	logic [15:0] mem [0:(1 << tmb_aw)-1];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

//--- hw/video_ts.sv
`timescale 1ns/1ps

module video_ts (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          start,
	input  logic [8:0]                    line,
	input  logic                          v_ts,
	input  logic                          v_pf,
	input  logic [7:0]                    tsconf,
	input  logic [7:0]                    t0gpage,
	input  logic [7:0]                    t1gpage,
	input  logic [7:0]                    sgpage,
	input  logic [7:0]                    tmpage,
	input  logic [5:0]                    num_tiles,
	input  logic [8:0]                    t0x_offs,
	input  logic [8:0]                    t1x_offs,
	input  logic [8:0]                    t0y_offs,
	input  logic [8:0]                    t1y_offs,
	input  logic [1:0]                    t0_palsel,
	input  logic [1:0]                    t1_palsel,
	output logic [ts_pkg::sfile_aw-1:0]   sfile_raddr,
	input  ts_pkg::sfile_word_u           sfile_rdata,
	output logic [ts_pkg::tmb_aw-1:0]     tmb_waddr,
	output logic                          tmb_we,
	output logic [ts_pkg::tmb_aw-1:0]     tmb_raddr,
	input  ts_pkg::tile_desc_t            tmb_rdata,
	output logic                          tm_req,
	output logic [ts_pkg::gfx_addr_w-1:0] tm_addr,
	input  logic                          tm_next,
	ts_task_if.seq                        tsk
);
	import ts_pkg::*;

	typedef enum logic [2:0] {sp_a0, sp_r0, sp_a1, sp_r1, sp_r2} sp_state_t;

	logic s_en;
	logic t1_en;
	logic t0_en;
	logic t1z_en;
	logic t0z_en;

	logic [layers-1:0] layer;
	logic [layers-1:0] layer_act;
	logic [layers-1:0] layer_skip;
	logic [layers-1:0] layer_en;
	logic [layers-1:0] layer_ok;
	logic [layers-1:0] layer_end;

	logic [4:0] tm_x;
	logic [4:0] tm_last;
	logic       tm_done;
	logic       tm_end;
	logic       tm_layer;
	logic [8:0] tm_line;
	logic [5:0] tm_row;

	logic [1:0] t_layer;
	logic       t_sel;
	logic       t_cur;
	logic [5:0] tx;
	logic       t_vld;
	logic       t_done;
	logic       t_act;
	logic       t_step;
	logic       t_layer_end;
	logic [1:0] tile_end;
	logic       tile_go;
	logic [8:0] tx_offs;
	logic [2:0] ty_offs;
	logic [4:0] t_line;
	logic [8:0] tile_line;

	sp_state_t  sp_state;
	logic [7:0] sbase;
	logic [2:0] s_layer;
	logic       s_cur;
	logic       s_last;
	logic       s_ok;
	logic       s_skip;
	logic       s_layer_end;
	logic [2:0] spr_end;
	logic       sprite_go;
	logic       spr_sel;
	logic       s_leap_r;
	logic [5:0] s_off_r;
	logic [8:0] spr_x_r;
	logic [2:0] spr_xs_r;
	logic       spr_xf_r;
	logic [8:0] s_line;
	logic [5:0] s_ymax;
	logic [5:0] s_off;
	logic [8:0] spr_line;

	assign s_en   = tsconf[7];
	assign t1_en  = tsconf[6];
	assign t0_en  = tsconf[5];
	assign t1z_en = tsconf[3];
	assign t0z_en = tsconf[2];

	// layer walker, one-hot position plus per-layer skip flags
	assign layer_en = {s_en, t1_en, s_en, t0_en, s_en, t1_en | t0_en};
	assign layer_ok = {{(layers-1){v_ts}}, v_pf};

	always_comb
	begin
		layer_end         = '0;
		layer_end[lyr_tm] = tm_end;
		layer_end[lyr_s0] = spr_end[0];
		layer_end[lyr_t0] = tile_end[0];
		layer_end[lyr_s1] = spr_end[1];
		layer_end[lyr_t1] = tile_end[1];
		layer_end[lyr_s2] = spr_end[2];
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			layer      <= '0;
			layer_act  <= '0;
			layer_skip <= '1;
		end
		else if (start)
		begin
			layer      <= layers'(1);
			layer_act  <= '0;
			layer_skip <= ~(layer_en & layer_ok);
		end
		else
		begin
			if (|(layer & layer_skip))
				layer <= layer << 1;
			layer_act  <= layer & ~layer_skip;
			layer_skip <= layer_skip | layer_end;
		end
	end

	// tilemap prefetch, 16 lines ahead, 8 words per plane
	assign tm_line   = line + 9'd16;
	assign tm_layer  = tm_x[3];
	assign tm_row    = tm_line[8:3] + (tm_layer ? t1y_offs[8:3] : t0y_offs[8:3]);
	assign tm_last   = t1_en ? 5'd16 : 5'd8;
	assign tm_done   = tm_x == tm_last;
	assign tm_req    = layer_act[lyr_tm] && !tm_done;
	assign tm_end    = layer_act[lyr_tm] && tm_done;
	assign tm_addr   = {tmpage, tm_row, tm_layer, tm_line[2:0], tm_x[2:0]};
	assign tmb_we    = tm_req && tm_next;
	assign tmb_waddr = {tm_line[4:3], tm_line[2:0], tm_x[2:0], tm_layer};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tm_x <= '0;
		else if (start)
			tm_x <= t0_en ? 5'd0 : 5'd8;
		else if (tmb_we)
			tm_x <= tm_x + 5'd1;
	end

	// tile walker, t_vld marks tmb_rdata valid for tx
	assign t_sel     = t_layer[0];
	assign t_cur     = (t_layer[0] && layer_act[lyr_t0]) || (t_layer[1] && layer_act[lyr_t1]);
	assign tx_offs   = t_sel ? t0x_offs : t1x_offs;
	assign ty_offs   = t_sel ? t0y_offs[2:0] : t1y_offs[2:0];
	assign t_line    = line[4:0] + {2'b00, ty_offs};
	assign tmb_raddr = {t_line[4:3], tx + tx_offs[8:3], ~t_sel};
	// tile 0 is see-through unless zero-enable is set for the plane
	assign t_act     = (tmb_rdata.tnum != '0) || (t_sel ? t0z_en : t1z_en);
	assign t_done    = tx == num_tiles;
	assign t_layer_end = t_cur && t_done;
	assign tile_end  = {2{t_layer_end}} & t_layer;
	assign tile_go   = t_vld && t_act && tsk.rdy;
	assign t_step    = t_vld && (!t_act || tsk.rdy);
	assign tile_line = {tmb_rdata.tnum[11:6], t_line[2:0] ^ {3{tmb_rdata.yflp}}};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			t_layer <= '0;
			tx      <= '0;
			t_vld   <= 1'b0;
		end
		else if (start)
		begin
			t_layer <= t0_en ? 2'b01 : 2'b10;
			tx      <= '0;
			t_vld   <= 1'b0;
		end
		else
		begin
			if (t_layer_end)
			begin
				t_layer <= t_layer << 1;
				tx      <= '0;
			end
			else if (t_step)
				tx <= tx + 6'd1;
			t_vld <= t_cur && !t_done && !t_step;
		end
	end

	// sprite walker, sbase points at r0 of the current sprite
	assign s_cur  = |(s_layer & {layer_act[lyr_s2], layer_act[lyr_s1], layer_act[lyr_s0]});
	assign s_last = sbase == sfile_last;
	assign s_line = line - sfile_rdata.r0.ycrd;
	assign s_ymax = {sfile_rdata.r0.ysz, 3'b111};
	assign s_ok   = sfile_rdata.r0.act && (s_line <= {3'b000, s_ymax});
	assign s_off  = sfile_rdata.r0.yflp ? (s_ymax - s_line[5:0]) : s_line[5:0];
	assign s_skip = (sp_state == sp_r0) && !s_ok;
	assign sprite_go   = (sp_state == sp_r2) && tsk.rdy;
	assign s_layer_end = (s_skip && sfile_rdata.r0.leap) || (sprite_go && s_leap_r);
	assign spr_end     = ({3{s_layer_end}} & s_layer) | {3{s_last}};
	assign spr_line    = {sfile_rdata.r2.tnum[11:6], 3'b000} + {3'b000, s_off_r};

	always_comb
	begin
		case (sp_state)
			sp_a1:        sfile_raddr = sbase + 8'd1;
			sp_r1, sp_r2: sfile_raddr = sbase + 8'd2;
			default:      sfile_raddr = sbase;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sp_state <= sp_a0;
			sbase    <= '0;
			s_layer  <= '0;
		end
		else if (start)
		begin
			sp_state <= sp_a0;
			sbase    <= '0;
			s_layer  <= 3'b001;
		end
		else
		begin
			if (s_layer_end)
				s_layer <= s_layer << 1;
			case (sp_state)
				sp_a0:
					if (s_cur && !s_last)
						sp_state <= sp_r0;
				sp_r0:
					if (s_ok)
						sp_state <= sp_a1;
					else
					begin
						sp_state <= sp_a0;
						sbase    <= sbase + 8'd3;
					end
				sp_a1:
					sp_state <= sp_r1;
				sp_r1:
					sp_state <= sp_r2;
				sp_r2:
					if (tsk.rdy)
					begin
						sp_state <= sp_a0;
						sbase    <= sbase + 8'd3;
					end
				default:
					sp_state <= sp_a0;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (sp_state == sp_r0)
		begin
			s_leap_r <= sfile_rdata.r0.leap;
			s_off_r  <= s_off;
		end
		if (sp_state == sp_r1)
		begin
			spr_x_r  <= sfile_rdata.r1.xcrd;
			spr_xs_r <= sfile_rdata.r1.xsz;
			spr_xf_r <= sfile_rdata.r1.xflp;
		end
	end

	// task fields, sprites or tiles by active layer
	assign spr_sel  = layer_act[lyr_s0] || layer_act[lyr_s1] || layer_act[lyr_s2];
	assign tsk.go   = sprite_go || tile_go;
	assign tsk.page = spr_sel ? sgpage : (t_sel ? t0gpage : t1gpage);
	assign tsk.line = spr_sel ? spr_line : tile_line;
	assign tsk.addr = spr_sel ? sfile_rdata.r2.tnum[5:0] : tmb_rdata.tnum[5:0];
	assign tsk.x    = spr_sel ? spr_x_r : ({tx, 3'b000} - {6'd0, tx_offs[2:0]});
	assign tsk.xs   = spr_sel ? spr_xs_r : 3'd0;
	assign tsk.xf   = spr_sel ? spr_xf_r : tmb_rdata.xflp;
	assign tsk.pal  = spr_sel ? sfile_rdata.r2.pal
		: {(t_sel ? t0_palsel : t1_palsel), tmb_rdata.pal};

endmodule

//--- hw/video_ts_render.sv
`timescale 1ns/1ps

module video_ts_render #(
	parameter int lb_x_w = 9
) (
	input  logic                          clk,
	input  logic                          rst_n,
	ts_task_if.rend                       tsk,
	output logic                          gfx_req,
	output logic [ts_pkg::gfx_addr_w-1:0] gfx_addr,
	input  logic                          gfx_next,
	input  logic [15:0]                   gfx_rdata,
	output logic                          lb_we,
	output logic [lb_x_w-1:0]             lb_addr,
	output logic [7:0]                    lb_data
);
	import ts_pkg::*;

	typedef enum logic [1:0] {r_idle, r_fetch, r_pix} r_state_t;

	r_state_t          state;
	logic [7:0]        page_r;
	logic [8:0]        line_r;
	logic [5:0]        addr_r;
	logic [lb_x_w-1:0] x_r;
	logic [2:0]        xs_r;
	logic              xf_r;
	logic [3:0]        pal_r;
	logic [15:0]       data_r;
	logic [3:0]        wcnt;
	logic [1:0]        slot;
	logic [3:0]        wlast;
	logic [3:0]        woff;
	logic [6:0]        word;
	logic [3:0]        nib;

	assign tsk.rdy = state == r_idle;
	assign gfx_req = state == r_fetch;

	// two words per 8 pixels, flipped tasks walk from the far end
	assign wlast    = {xs_r, 1'b1};
	assign woff     = xf_r ? (wlast - wcnt) : wcnt;
	assign word     = {addr_r, 1'b0} + {3'b000, woff};
	// line bits 8:6 overlap the page field and are added
	assign gfx_addr = {page_r, 13'd0} + gfx_addr_w'({line_r, word});

	// high nibble first, low nibble first when flipped
	assign nib     = xf_r ? data_r[{slot, 2'b00} +: 4] : data_r[{~slot, 2'b00} +: 4];
	assign lb_we   = (state == r_pix) && (nib != 4'd0);
	assign lb_addr = x_r + lb_x_w'({wcnt, slot});
	assign lb_data = {pal_r, nib};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= r_idle;
			wcnt  <= '0;
			slot  <= '0;
		end
		else
		begin
			case (state)
				r_idle:
					if (tsk.go)
					begin
						state <= r_fetch;
						wcnt  <= '0;
					end
				r_fetch:
					if (gfx_next)
					begin
						state <= r_pix;
						slot  <= '0;
					end
				r_pix:
				begin
					slot <= slot + 2'd1;
					if (slot == 2'd3)
					begin
						if (wcnt == wlast)
							state <= r_idle;
						else
						begin
							wcnt  <= wcnt + 4'd1;
							state <= r_fetch;
						end
					end
				end
				default:
					state <= r_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == r_idle && tsk.go)
		begin
			page_r <= tsk.page;
			line_r <= tsk.line;
			addr_r <= tsk.addr;
			x_r    <= lb_x_w'(tsk.x);
			xs_r   <= tsk.xs;
			xf_r   <= tsk.xf;
			pal_r  <= tsk.pal;
		end
		if (state == r_fetch && gfx_next)
			data_r <= gfx_rdata;
	end

endmodule

//--- hw/video_ts_top.sv
`timescale 1ns/1ps

module video_ts_top #(
	parameter int lb_x_w = 9
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          start,
	input  logic [8:0]                    line,
	input  logic                          v_ts,
	input  logic                          v_pf,
	input  logic [7:0]                    tsconf,
	input  logic [7:0]                    t0gpage,
	input  logic [7:0]                    t1gpage,
	input  logic [7:0]                    sgpage,
	input  logic [7:0]                    tmpage,
	input  logic [5:0]                    num_tiles,
	input  logic [8:0]                    t0x_offs,
	input  logic [8:0]                    t1x_offs,
	input  logic [8:0]                    t0y_offs,
	input  logic [8:0]                    t1y_offs,
	input  logic [1:0]                    t0_palsel,
	input  logic [1:0]                    t1_palsel,
	input  logic [ts_pkg::sfile_aw-1:0]   sfile_addr,
	input  logic [15:0]                   sfile_data,
	input  logic                          sfile_we,
	output logic                          tm_req,
	output logic [ts_pkg::gfx_addr_w-1:0] tm_addr,
	input  logic                          tm_next,
	input  logic [15:0]                   tm_rdata,
	output logic                          gfx_req,
	output logic [ts_pkg::gfx_addr_w-1:0] gfx_addr,
	input  logic                          gfx_next,
	input  logic [15:0]                   gfx_rdata,
	output logic                          lb_we,
	output logic [lb_x_w-1:0]             lb_addr,
	output logic [7:0]                    lb_data
);
	import ts_pkg::*;

	logic [sfile_aw-1:0] sfile_raddr;
	sfile_word_u         sfile_rdata;
	logic [tmb_aw-1:0]   tmb_waddr;
	logic [tmb_aw-1:0]   tmb_raddr;
	logic                tmb_we;
	tile_desc_t          tmb_rdata;

	ts_task_if u_task ();

	video_ts u_ts (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.line        (line),
		.v_ts        (v_ts),
		.v_pf        (v_pf),
		.tsconf      (tsconf),
		.t0gpage     (t0gpage),
		.t1gpage     (t1gpage),
		.sgpage      (sgpage),
		.tmpage      (tmpage),
		.num_tiles   (num_tiles),
		.t0x_offs    (t0x_offs),
		.t1x_offs    (t1x_offs),
		.t0y_offs    (t0y_offs),
		.t1y_offs    (t1y_offs),
		.t0_palsel   (t0_palsel),
		.t1_palsel   (t1_palsel),
		.sfile_raddr (sfile_raddr),
		.sfile_rdata (sfile_rdata),
		.tmb_waddr   (tmb_waddr),
		.tmb_we      (tmb_we),
		.tmb_raddr   (tmb_raddr),
		.tmb_rdata   (tmb_rdata),
		.tm_req      (tm_req),
		.tm_addr     (tm_addr),
		.tm_next     (tm_next),
		.tsk         (u_task)
	);

	video_sfile u_sfile (
		.clk   (clk),
		.waddr (sfile_addr),
		.wdata (sfile_data),
		.we    (sfile_we),
		.raddr (sfile_raddr),
		.rdata (sfile_rdata)
	);

	// prefetched tilemap words go straight into the buffer
	video_tmbuf u_tmbuf (
		.clk   (clk),
		.waddr (tmb_waddr),
		.wdata (tm_rdata),
		.we    (tmb_we),
		.raddr (tmb_raddr),
		.rdata (tmb_rdata)
	);

	video_ts_render #(
		.lb_x_w (lb_x_w)
	) u_render (
		.clk       (clk),
		.rst_n     (rst_n),
		.tsk       (u_task),
		.gfx_req   (gfx_req),
		.gfx_addr  (gfx_addr),
		.gfx_next  (gfx_next),
		.gfx_rdata (gfx_rdata),
		.lb_we     (lb_we),
		.lb_addr   (lb_addr),
		.lb_data   (lb_data)
	);

endmodule

//--- verif/video_ts_assertions.sv
`timescale 1ns/1ps

module video_ts_assertions (
	input logic        clk,
	input logic        rst_n,
	input logic [7:0]  tmpage,
	input logic        tm_req,
	input logic [20:0] tm_addr,
	input logic        tm_next,
	input logic        gfx_req,
	input logic [20:0] gfx_addr,
	input logic        gfx_next,
	input logic        lb_we,
	input logic [7:0]  lb_data
);

	logic gfx_hs;
	int   fail_count = 0;

	assign gfx_hs = gfx_req && gfx_next;

	reset_quiet: assert property (@(posedge clk) !rst_n |-> !tm_req && !gfx_req && !lb_we)
	else
	begin
		$error("DRAM request or line buffer write during reset");
		fail_count++;
	end

	tm_page: assert property (@(posedge clk) disable iff (!rst_n)
		tm_req |-> tm_addr[20:13] == tmpage)
	else
	begin
		$error("tm_addr outside the tilemap page");
		fail_count++;
	end

	// a waiting client keeps its request
	tm_hold: assert property (@(posedge clk) disable iff (!rst_n)
		tm_req && !tm_next |=> tm_req && $stable(tm_addr))
	else
	begin
		$error("tm_req or tm_addr changed while waiting");
		fail_count++;
	end

	gfx_hold: assert property (@(posedge clk) disable iff (!rst_n)
		gfx_req && !gfx_next |=> gfx_req && $stable(gfx_addr))
	else
	begin
		$error("gfx_req or gfx_addr changed while waiting");
		fail_count++;
	end

	// four pixel slots follow every word
	gfx_pace: assert property (@(posedge clk) disable iff (!rst_n)
		gfx_req |-> !($past(gfx_hs, 1) || $past(gfx_hs, 2) || $past(gfx_hs, 3)
			|| $past(gfx_hs, 4)))
	else
	begin
		$error("gfx_req within 4 cycles of a gfx_next");
		fail_count++;
	end

	lb_opaque: assert property (@(posedge clk) disable iff (!rst_n)
		lb_we |-> lb_data[3:0] != 4'd0)
	else
	begin
		$error("transparent pixel written to the line buffer");
		fail_count++;
	end

endmodule

bind video_ts_top video_ts_assertions u_video_ts_assertions (
	.clk      (clk),
	.rst_n    (rst_n),
	.tmpage   (tmpage),
	.tm_req   (tm_req),
	.tm_addr  (tm_addr),
	.tm_next  (tm_next),
	.gfx_req  (gfx_req),
	.gfx_addr (gfx_addr),
	.gfx_next (gfx_next),
	.lb_we    (lb_we),
	.lb_data  (lb_data)
);

//--- verif/tb_video_ts_top.sv
`timescale 1ns/1ps

module tb_video_ts_top;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        start;
	logic [8:0]  line;
	logic        v_ts;
	logic        v_pf;
	logic [7:0]  tsconf;
	logic [7:0]  t0gpage;
	logic [7:0]  t1gpage;
	logic [7:0]  sgpage;
	logic [7:0]  tmpage;
	logic [5:0]  num_tiles;
	logic [8:0]  t0x_offs;
	logic [8:0]  t1x_offs;
	logic [8:0]  t0y_offs;
	logic [8:0]  t1y_offs;
	logic [1:0]  t0_palsel;
	logic [1:0]  t1_palsel;
	logic [7:0]  sfile_addr;
	logic [15:0] sfile_data;
	logic        sfile_we;
	logic        tm_req;
	logic [20:0] tm_addr;
	logic        tm_next = 1'b0;
	logic [15:0] tm_rdata = 16'h0000;
	logic        gfx_req;
	logic [20:0] gfx_addr;
	logic        gfx_next = 1'b0;
	logic [15:0] gfx_rdata = 16'h0000;
	logic        lb_we;
	logic [8:0]  lb_addr;
	logic [7:0]  lb_data;

	// running totals kept by the bus monitor
	int tm_hs = 0;
	int gfx_hs = 0;
	int tm_reqs = 0;
	int gfx_reqs = 0;
	int lb_wrs = 0;
	int mon_errors = 0;

	int          seq_errors;
	int          test_err0;
	int          passed;
	int          failed;
	logic        hung;
	logic [7:0]  exp_gpage;
	logic [3:0]  exp_pal;
	logic [8:0]  exp_x_lo;
	logic [8:0]  exp_x_hi;
	logic [31:0] dram_rnd;

	video_ts_top u_video_ts_top (.*);

	always #2 clk = ~clk;

	function automatic int error_count();
		return seq_errors + mon_errors + u_video_ts_top.u_video_ts_assertions.fail_count;
	endfunction

	// DRAM clients, random next gaps and data
	always @(posedge clk)
	begin
		#1;
		dram_rnd = $urandom;
		tm_next = dram_rnd[1:0] != 2'b00;
		gfx_next = dram_rnd[3:2] != 2'b00;
		// tile descriptors: palette 2, tile number odd and below 512
		tm_rdata = {dram_rnd[31:30], 2'b10, 3'b000, dram_rnd[24:17], 1'b1};
		gfx_rdata = dram_rnd[31:16] | 16'h1000;
	end

	always @(posedge clk)
	begin
		if (tm_req)
			tm_reqs++;
		if (tm_req && tm_next)
			tm_hs++;
		if (gfx_req)
			gfx_reqs++;
		if (gfx_req && gfx_next)
		begin
			gfx_hs++;
			assert (gfx_addr[20:13] == exp_gpage)
			else
			begin
				$display("Error at time %0t: gfx_addr page %h, expected %h",
					$time, gfx_addr[20:13], exp_gpage);
				mon_errors++;
			end
		end
		if (lb_we)
		begin
			lb_wrs++;
			assert (lb_data[7:4] == exp_pal)
			else
			begin
				$display("Error at time %0t: lb_data palette %h, expected %h",
					$time, lb_data[7:4], exp_pal);
				mon_errors++;
			end
			assert (lb_addr >= exp_x_lo && lb_addr <= exp_x_hi)
			else
			begin
				$display("Error at time %0t: lb_addr %0d, expected %0d to %0d",
					$time, lb_addr, exp_x_lo, exp_x_hi);
				mon_errors++;
			end
		end
	end

	task automatic next_cycle;
		@(posedge clk);
		#1;
	endtask

	task automatic check_that(input logic ok, input string msg);
		assert (ok)
		else
		begin
			$display("Error at time %0t: %s", $time, msg);
			seq_errors++;
		end
	endtask

	// done once nothing moves on the DRAM ports or the line buffer for a while
	task automatic wait_quiet;
		int quiet;
		int cycles;
		quiet = 0;
		cycles = 0;
		while (quiet < 32 && cycles < 5000)
		begin
			@(posedge clk);
			if (tm_req || gfx_req || lb_we)
				quiet = 0;
			else
				quiet++;
			cycles++;
		end
		#1;
		if (quiet < 32)
		begin
			$display("Timeout: DUT still busy after %0d cycles at time %0t", cycles, $time);
			seq_errors++;
			hung = 1'b1;
		end
	endtask

	task automatic run_line(input logic [8:0] l);
		line = l;
		start = 1'b1;
		next_cycle;
		start = 1'b0;
		if (!hung)
			wait_quiet;
	endtask

	task automatic write_sfile(input logic [7:0] addr, input logic [15:0] data);
		sfile_addr = addr;
		sfile_data = data;
		sfile_we = 1'b1;
		next_cycle;
		sfile_we = 1'b0;
	endtask

	// y 48 size 0 with leap set, x 40, tile 5, palette 9
	task automatic load_sprite(input logic [7:0] base, input logic act, input logic [2:0] xs);
		write_sfile(base, {1'b0, 1'b1, act, 1'b0, 3'b000, 9'd48});
		write_sfile(base + 8'd1, {1'b0, 3'b000, xs, 9'd40});
		write_sfile(base + 8'd2, {4'h9, 12'h005});
	endtask

	task automatic begin_test;
		test_err0 = error_count();
	endtask

	task automatic end_test(input string name);
		if (error_count() == test_err0)
		begin
			passed++;
			$display("test %s: pass", name);
		end
		else
		begin
			failed++;
			$display("test %s: fail", name);
		end
	endtask

	initial
	begin
		int i;
		int hs0;
		int req0;
		int wr0;
		void'($urandom(37));
		rst_n = 1'b0;
		start = 1'b0;
		line = '0;
		v_ts = 1'b0;
		v_pf = 1'b0;
		tsconf = '0;
		t0gpage = 8'h47;
		t1gpage = 8'h12;
		sgpage = 8'h33;
		tmpage = 8'h5a;
		num_tiles = 6'd4;
		t0x_offs = '0;
		t1x_offs = '0;
		t0y_offs = '0;
		t1y_offs = '0;
		t0_palsel = 2'b11;
		t1_palsel = 2'b01;
		sfile_addr = '0;
		sfile_data = '0;
		sfile_we = 1'b0;
		seq_errors = 0;
		passed = 0;
		failed = 0;
		hung = 1'b0;
		exp_gpage = '0;
		exp_pal = '0;
		exp_x_lo = '0;
		exp_x_hi = '0;

		begin_test;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (4) next_cycle;
		check_that(tm_reqs == 0 && gfx_reqs == 0 && lb_wrs == 0, "activity around reset");
		end_test("reset quiet");

		begin_test;
		v_ts = 1'b1;
		v_pf = 1'b1;
		run_line(9'd10);
		check_that(tm_reqs == 0 && gfx_reqs == 0 && lb_wrs == 0, "activity with layers off");
		end_test("disabled layers");

		// lines 0 to 31 fill all four tilemap buffer slots for plane 0
		begin_test;
		tsconf = 8'h20;
		v_ts = 1'b0;
		req0 = tm_reqs;
		for (i = 0; i < 32; i++)
		begin
			hs0 = tm_hs;
			run_line(9'(i));
			check_that(tm_hs - hs0 == 8,
				$sformatf("line %0d had %0d tm_next handshakes", i, tm_hs - hs0));
		end
		check_that(tm_reqs > req0, "tm_req never rose");
		end_test("tilemap prefetch");

		begin_test;
		tsconf = 8'h80;
		v_ts = 1'b1;
		v_pf = 1'b0;
		exp_gpage = sgpage;
		exp_pal = 4'h9;
		// 8 pixels from x 40
		exp_x_lo = 9'd40;
		exp_x_hi = 9'd47;
		for (i = 0; i < 256; i++)
			write_sfile(8'(i), 16'h0000);
		load_sprite(8'd0, 1'b1, 3'd0);
		load_sprite(8'd3, 1'b0, 3'd0);
		load_sprite(8'd6, 1'b0, 3'd0);
		hs0 = gfx_hs;
		wr0 = lb_wrs;
		run_line(9'd50);
		check_that(gfx_hs - hs0 == 2,
			$sformatf("sprite took %0d gfx_next handshakes", gfx_hs - hs0));
		check_that(lb_wrs > wr0, "sprite wrote no pixels");
		load_sprite(8'd0, 1'b0, 3'd0);
		req0 = gfx_reqs;
		run_line(9'd50);
		check_that(gfx_reqs == req0, "inactive sprite raised gfx_req");
		end_test("sprite rendering");

		// sprite of size 3, 8 words paced by the pixel slots
		begin_test;
		exp_x_hi = 9'd71;
		load_sprite(8'd0, 1'b1, 3'd3);
		hs0 = gfx_hs;
		run_line(9'd50);
		check_that(gfx_hs - hs0 == 8,
			$sformatf("sprite of size 3 took %0d gfx_next handshakes", gfx_hs - hs0));
		end_test("renderer pacing");

		begin_test;
		tsconf = 8'h20;
		v_pf = 1'b1;
		exp_gpage = t0gpage;
		exp_pal = {t0_palsel, 2'b10};
		// 4 tiles of 8 pixels from x 0
		exp_x_lo = 9'd0;
		exp_x_hi = 9'd31;
		hs0 = gfx_hs;
		wr0 = lb_wrs;
		run_line(9'd5);
		check_that(gfx_hs - hs0 == 8,
			$sformatf("4 tiles took %0d gfx_next handshakes", gfx_hs - hs0));
		check_that(lb_wrs > wr0, "tiles wrote no pixels");
		end_test("tile rendering");

		$display("%0d tests passed, %0d failed, %0d errors", passed, failed, error_count());
		if (error_count() == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- video_ts_top.f
hw/ts_pkg.sv
hw/ts_task_if.sv
hw/video_sfile.sv
hw/video_tmbuf.sv
hw/video_ts.sv
hw/video_ts_render.sv
hw/video_ts_top.sv
verif/video_ts_assertions.sv
verif/tb_video_ts_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_video_ts_top -f video_ts_top.f
	./obj_dir/Vtb_video_ts_top > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@! grep -q "CHECKS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
